/* hw/eeprom_settings.svh */
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// byte address of a 2 Kbyte part, top 3 bits go in the device select
`define EEPROM_ADDR_W    11

`define EEPROM_CMD_DEPTH 4
`define EEPROM_RD_DEPTH  2

`define EEPROM_DEV_CODE  4'b1010
`define EEPROM_DROP_W    8

`endif

/* hw/eeprom_pkg.sv */
`include "eeprom_settings.svh"

package eeprom_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    typedef struct packed {
        eeprom_op_e                op;
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [7:0]                wdata; // don't care for reads
    } eeprom_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       nack;  // slave refused a byte, data forced to 00
    } eeprom_rdata_t;

endpackage

/* hw/eeprom_fifo.sv */
`timescale 1ns/1ps

module eeprom_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == FULL_CNT);
    assign dout    = mem[rd_ptr]; // head is always visible

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_push_full : assert property (@(posedge CLK) disable iff (RESET) push |-> !full);
    a_pop_empty : assert property (@(posedge CLK) disable iff (RESET) pop |-> !empty);

endmodule

/* hw/eeprom_req_capture.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_req_capture (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [7:0]                wdata,
    input  logic                      full,
    output logic                      push,
    output eeprom_pkg::eeprom_cmd_t   cmd,
    output logic [`EEPROM_DROP_W-1:0] drop_count
);
    logic                     pending;
    logic [1:0]               drop_inc;
    logic [`EEPROM_DROP_W:0]  drop_sum;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pending <= 1'b0;
        else
            pending <= wr | rd;
    end

    // write wins when both strobes arrive together
    always_ff @(posedge CLK)
    begin
        if (wr | rd)
        begin
            cmd.op    <= wr ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ;
            cmd.addr  <= addr;
            cmd.wdata <= wdata;
        end
    end

    assign push = pending && !full;

    assign drop_inc = {1'b0, wr & rd} + {1'b0, pending & full};
    assign drop_sum = {1'b0, drop_count} + {{(`EEPROM_DROP_W - 1){1'b0}}, drop_inc};

    always_ff @(posedge CLK)
    begin
        if (RESET)
            drop_count <= '0;
        else if (drop_sum[`EEPROM_DROP_W])
            drop_count <= '1; // saturate
        else
            drop_count <= drop_sum[`EEPROM_DROP_W-1:0];
    end

    // a request lost to a full queue moves the counter until it saturates
    a_drop_counted : assert property (@(posedge CLK) disable iff (RESET)
        (pending && full && (drop_count != '1)) |=> (drop_count != $past(drop_count)));

endmodule

/* hw/eeprom_serial_ctrl.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_serial_ctrl (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      cmd_empty,
    output logic                      cmd_pop,
    input  eeprom_pkg::eeprom_cmd_t   cmd,
    input  logic                      rd_full,
    output logic                      rd_push,
    output eeprom_pkg::eeprom_rdata_t rd_result,
    output logic                      scl,
    output logic                      sda_o,
    output logic                      sda_oe,
    input  logic                      sda_i,
    output logic                      busy
);
    typedef enum logic [8:0] {
        ST_IDLE    = 9'b0_0000_0001,
        ST_START   = 9'b0_0000_0010,
        ST_CTRL_WR = 9'b0_0000_0100,
        ST_ADDR_WR = 9'b0_0000_1000,
        ST_DATA_WR = 9'b0_0001_0000,
        ST_RSTART  = 9'b0_0010_0000,
        ST_CTRL_RD = 9'b0_0100_0000,
        ST_DATA_RD = 9'b0_1000_0000,
        ST_STOP    = 9'b1_0000_0000
    } state_e;

    state_e                  state;
    state_e                  ack_next;
    eeprom_pkg::eeprom_cmd_t cmd_q;
    logic [7:0]              shreg;     // shared by send and receive
    logic [3:0]              bit_cnt;   // 0..7 data, 8 ack slot
    logic                    ph;        // 0 scl low, 1 scl high
    logic [1:0]              seq;       // step inside start, rstart, stop
    logic                    nack_q;
    logic                    in_byte;
    logic                    ack_end;
    logic                    shift_en;
    logic                    load_en;
    logic [7:0]              load_val;
    logic [7:0]              ctrl_wr_byte;
    logic [7:0]              ctrl_rd_byte;

    assign ctrl_wr_byte = {`EEPROM_DEV_CODE, cmd_q.addr[`EEPROM_ADDR_W-1:8], 1'b0};
    assign ctrl_rd_byte = {`EEPROM_DEV_CODE, cmd_q.addr[`EEPROM_ADDR_W-1:8], 1'b1};

    assign in_byte  = state inside {ST_CTRL_WR, ST_ADDR_WR, ST_DATA_WR, ST_CTRL_RD, ST_DATA_RD};
    assign ack_end  = in_byte && ph && (bit_cnt == 4'd8);
    assign shift_en = in_byte && ph && (bit_cnt != 4'd8);

    assign cmd_pop = (state == ST_IDLE) && !cmd_empty && !rd_full;
    assign busy    = (state != ST_IDLE);
    assign rd_push = (state == ST_STOP) && (seq == 2'd2) && (cmd_q.op == eeprom_pkg::OP_READ);
    assign rd_result = '{data: nack_q ? 8'h00 : shreg, nack: nack_q};

    // next byte to shift and where the ack slot leads
    always_comb
    begin
        load_en  = 1'b0;
        load_val = ctrl_wr_byte;
        ack_next = ST_STOP;
        case (state)
            ST_START:
                load_en = (seq == 2'd1);
            ST_CTRL_WR:
            begin
                load_en  = ack_end && !sda_i;
                load_val = cmd_q.addr[7:0];
                if (!sda_i)
                    ack_next = ST_ADDR_WR;
            end
            ST_ADDR_WR:
            begin
                load_en  = ack_end && !sda_i && (cmd_q.op == eeprom_pkg::OP_WRITE);
                load_val = cmd_q.wdata;
                if (!sda_i)
                    ack_next = (cmd_q.op == eeprom_pkg::OP_READ) ? ST_RSTART : ST_DATA_WR;
            end
            ST_RSTART:
            begin
                load_en  = (seq == 2'd2);
                load_val = ctrl_rd_byte;
            end
            ST_CTRL_RD:
            begin
                if (!sda_i)
                    ack_next = ST_DATA_RD;
            end
            default:
                ack_next = ST_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_pop)
            cmd_q <= cmd;
        if (load_en)
            shreg <= load_val;
        else if (shift_en)
            shreg <= {shreg[6:0], sda_i};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            scl     <= 1'b1;
            sda_o   <= 1'b1;
            sda_oe  <= 1'b0;
            ph      <= 1'b0;
            bit_cnt <= '0;
            seq     <= '0;
            nack_q  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    scl     <= 1'b1;
                    sda_o   <= 1'b1;
                    sda_oe  <= 1'b0;
                    ph      <= 1'b0;
                    bit_cnt <= '0;
                    seq     <= '0;
                    if (cmd_pop)
                    begin
                        nack_q <= 1'b0;
                        state  <= ST_START;
                    end
                end
                ST_START:
                begin
                    seq <= seq + 1'b1;
                    if (seq == 2'd0)
                    begin
                        sda_oe <= 1'b1; // sda falls with scl high
                        sda_o  <= 1'b0;
                    end
                    else
                    begin
                        scl     <= 1'b0;
                        sda_o   <= load_val[7];
                        ph      <= 1'b0;
                        bit_cnt <= '0;
                        state   <= ST_CTRL_WR;
                    end
                end
                ST_RSTART:
                begin
                    seq <= seq + 1'b1;
                    case (seq)
                        2'd0:
                            scl <= 1'b1;
                        2'd1:
                            sda_o <= 1'b0; // repeated start
                        default:
                        begin
                            scl     <= 1'b0;
                            sda_o   <= load_val[7];
                            ph      <= 1'b0;
                            bit_cnt <= '0;
                            state   <= ST_CTRL_RD;
                        end
                    endcase
                end
                ST_STOP:
                begin
                    seq <= seq + 1'b1;
                    case (seq)
                        2'd0:
                            scl <= 1'b1;
                        2'd1:
                        begin
                            sda_oe <= 1'b0; // sda rises with scl high
                            sda_o  <= 1'b1;
                        end
                        default:
                            state <= ST_IDLE;
                    endcase
                end
                default:
                begin
                    ph <= ~ph;
                    if (!ph)
                        scl <= 1'b1;
                    else if (bit_cnt != 4'd8)
                    begin
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd7)
                        begin
                            sda_oe <= (state == ST_DATA_RD); // master nack ends the read
                            sda_o  <= 1'b1;
                        end
                        else
                        begin
                            sda_oe <= (state != ST_DATA_RD);
                            sda_o  <= shreg[6];
                        end
                    end
                    else
                    begin
                        scl     <= 1'b0;
                        bit_cnt <= '0;
                        seq     <= '0;
                        state   <= ack_next;
                        if (state != ST_DATA_RD && sda_i)
                            nack_q <= 1'b1;
                        case (ack_next)
                            ST_DATA_RD:
                                sda_oe <= 1'b0;
                            ST_RSTART:
                            begin
                                sda_oe <= 1'b1;
                                sda_o  <= 1'b1;
                            end
                            ST_STOP:
                            begin
                                sda_oe <= 1'b1;
                                sda_o  <= 1'b0;
                            end
                            default:
                            begin
                                sda_oe <= 1'b1;
                                sda_o  <= load_val[7];
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // bus line, including the slave, holds steady from low phase through high phase
    a_sda_stable : assert property (@(posedge CLK) disable iff (RESET)
        (scl && in_byte) |-> $stable(sda_i));

endmodule

/* hw/eeprom_subsystem.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_subsystem (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [7:0]                wdata,
    input  logic                      rd_pop,
    output logic                      rd_valid,
    output logic [7:0]                rdata,
    output logic                      rd_nack,
    output logic [`EEPROM_DROP_W-1:0] drop_count,
    output logic                      busy,
    output logic                      scl,
    output logic                      sda_o,
    output logic                      sda_oe,
    input  logic                      sda_i
);
    logic                      cmd_push;
    logic                      cmd_pop;
    logic                      cmd_empty;
    logic                      cmd_full;
    eeprom_pkg::eeprom_cmd_t   cmd_in;
    eeprom_pkg::eeprom_cmd_t   cmd_head;
    logic                      rd_push;
    logic                      rd_empty;
    logic                      rd_full;
    eeprom_pkg::eeprom_rdata_t rd_result;
    eeprom_pkg::eeprom_rdata_t rd_head;

    assign rd_valid = !rd_empty;
    assign rdata    = rd_head.data;
    assign rd_nack  = rd_head.nack;

    eeprom_req_capture capture_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .full       (cmd_full),
        .push       (cmd_push),
        .cmd        (cmd_in),
        .drop_count (drop_count)
    );

    eeprom_fifo #(
        .payload_t (eeprom_pkg::eeprom_cmd_t),
        .DEPTH     (`EEPROM_CMD_DEPTH)
    ) cmd_fifo_i (
        .CLK   (CLK),
        .RESET (RESET),
        .push  (cmd_push),
        .din   (cmd_in),
        .pop   (cmd_pop),
        .dout  (cmd_head),
        .empty (cmd_empty),
        .full  (cmd_full)
    );

    eeprom_serial_ctrl ctrl_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .cmd       (cmd_head),
        .rd_full   (rd_full),
        .rd_push   (rd_push),
        .rd_result (rd_result),
        .scl       (scl),
        .sda_o     (sda_o),
        .sda_oe    (sda_oe),
        .sda_i     (sda_i),
        .busy      (busy)
    );

    eeprom_fifo #(
        .payload_t (eeprom_pkg::eeprom_rdata_t),
        .DEPTH     (`EEPROM_RD_DEPTH)
    ) rd_fifo_i (
        .CLK   (CLK),
        .RESET (RESET),
        .push  (rd_push),
        .din   (rd_result),
        .pop   (rd_pop),
        .dout  (rd_head),
        .empty (rd_empty),
        .full  (rd_full)
    );

endmodule

/* tb/eeprom_slave_model.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_slave_model #(
    parameter logic [2:0] NACK_BLOCK = 3'd7
) (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_low
);
    logic [7:0] mem [0:(1 << `EEPROM_ADDR_W) - 1];
    logic       prev_scl;
    logic       prev_sda;
    logic       active;
    logic       tx;
    logic       acked;
    logic       rnw;
    logic [3:0] bit_n;    // 8 means ack slot is next
    logic [1:0] byte_idx; // device select, word address, data
    logic [7:0] shreg;
    logic [2:0] blk;
    logic [7:0] word;

    initial
    begin
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
            mem[i] = 8'hff;
    end

    // line sampled on CLK, new drive value lands as scl falls
    always @(posedge CLK)
    begin
        if (RESET)
            active = 1'b0;
        else if (prev_scl && scl && prev_sda && !sda)
        begin
            active   = 1'b1; // start or repeated start
            tx       = 1'b0;
            bit_n    = '0;
            byte_idx = '0;
        end
        else if (prev_scl && scl && !prev_sda && sda)
            active = 1'b0;
        else if (active && !prev_scl && scl && tx)
        begin
            if (bit_n == 4'd8)
                active = 1'b0; // master ack slot, single byte reads only
            else
            begin
                bit_n = bit_n + 1'b1;
                shreg = {shreg[6:0], 1'b1};
                sda_low <= (bit_n != 4'd8) && !shreg[7];
            end
        end
        else if (active && !prev_scl && scl && bit_n != 4'd8)
        begin
            shreg = {shreg[6:0], sda};
            bit_n = bit_n + 1'b1;
            if (bit_n == 4'd8)
            begin
                acked = 1'b1;
                case (byte_idx)
                    2'd0:
                    begin
                        blk   = shreg[3:1];
                        rnw   = shreg[0];
                        acked = (shreg[7:4] == `EEPROM_DEV_CODE) && (shreg[3:1] != NACK_BLOCK);
                    end
                    2'd1:
                        word = shreg;
                    default:
                        mem[{blk, word}] = shreg;
                endcase
                sda_low <= acked;
            end
        end
        else if (active && !prev_scl && scl)
        begin
            // end of the ack slot
            bit_n = '0;
            if (!acked)
                active = 1'b0;
            else if (byte_idx == 2'd0 && rnw)
            begin
                tx    = 1'b1;
                shreg = mem[{blk, word}];
            end
            if (byte_idx != 2'd2)
                byte_idx = byte_idx + 1'b1;
            sda_low <= tx && !shreg[7];
        end
        if (!active)
            sda_low <= 1'b0;
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

/* tb/tb_eeprom_subsystem.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module tb_eeprom_subsystem;
    localparam int         N_CMDS   = 16 + 200 + 8 + 11 + 6 + 2;
    localparam int         CMD_CYC  = 120;
    localparam logic [2:0] NACK_BLK = 3'd7;

    logic                      CLK;
    logic                      RESET;
    logic                      wr;
    logic                      rd;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [7:0]                wdata;
    logic                      rd_pop;
    logic                      rd_valid;
    logic [7:0]                rdata;
    logic                      rd_nack;
    logic [`EEPROM_DROP_W-1:0] drop_count;
    logic                      busy;
    logic                      scl;
    logic                      sda_o;
    logic                      sda_oe;
    logic                      slave_low;
    wire                       sda;

    logic [7:0]                model [int];
    eeprom_pkg::eeprom_rdata_t exp_q [$];
    logic                      auto_pop;
    int                        errors;
    int                        checks;
    int                        test_err0;
    logic                      scl_q;
    int                        scl_rises;

    // open-drain line with pull-up
    assign sda = !((sda_oe && !sda_o) || slave_low);

    eeprom_subsystem eeprom_subsystem_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .rd_pop     (rd_pop),
        .rd_valid   (rd_valid),
        .rdata      (rdata),
        .rd_nack    (rd_nack),
        .drop_count (drop_count),
        .busy       (busy),
        .scl        (scl),
        .sda_o      (sda_o),
        .sda_oe     (sda_oe),
        .sda_i      (sda)
    );

    eeprom_slave_model #(
        .NACK_BLOCK (NACK_BLK)
    ) slave_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .scl     (scl),
        .sda     (sda),
        .sda_low (slave_low)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #5 CLK = ~CLK;
    end

    initial
    begin
        repeat (N_CMDS * CMD_CYC + 2000)
            @(posedge CLK);
        $display("watchdog expired before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

    task automatic check_eq(input string sig, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR %s got %0h expected %0h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic test_done(input string name);
        if (errors == test_err0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_err0);
        test_err0 = errors;
    endtask

    function automatic eeprom_pkg::eeprom_rdata_t expect_read(input logic [10:0] a);
        eeprom_pkg::eeprom_rdata_t r;
        r.nack = (a[10:8] == NACK_BLK);
        r.data = r.nack ? 8'h00 : model[a];
        return r;
    endfunction

    // issues one request and updates the model in issue order
    task automatic send(input logic w, input logic r, input logic [10:0] a, input logic [7:0] d);
        do
            @(posedge CLK);
        while (eeprom_subsystem_i.cmd_full);
        wr    <= w;
        rd    <= r;
        addr  <= a;
        wdata <= d;
        if (w)
        begin
            if (a[10:8] != NACK_BLK)
                model[a] = d;
        end
        else if (r)
            exp_q.push_back(expect_read(a));
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        repeat (2)
            @(posedge CLK);
    endtask

    task automatic wait_idle();
        do
            @(posedge CLK);
        while (busy || !eeprom_subsystem_i.cmd_empty);
    endtask

    task automatic drain();
        do
            @(posedge CLK);
        while (busy || !eeprom_subsystem_i.cmd_empty || exp_q.size() != 0 || rd_valid);
    endtask

    // scl rising edges seen on the bus
    always @(posedge CLK)
    begin
        if (scl && !scl_q)
            scl_rises++;
        scl_q <= scl;
    end

    // pops read results and compares them in issue order
    always @(posedge CLK)
    begin
        if (RESET || rd_pop)
            rd_pop <= 1'b0;
        else if (auto_pop && rd_valid)
        begin
            checks++;
            assert (exp_q.size() != 0)
            else
            begin
                $display("read result arrived with no read outstanding");
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                check_eq("rdata", rdata, exp_q[0].data);
                check_eq("rd_nack", rd_nack, exp_q[0].nack);
                void'(exp_q.pop_front());
            end
            rd_pop <= 1'b1;
        end
    end

    initial
    begin
        logic [10:0] a;
        logic [10:0] a_list [4];
        logic [7:0]  burst [6];
        logic [7:0]  d;
        int          drop0;
        int          rise0;

        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = '0;
        rd_pop    = 1'b0;
        auto_pop  = 1'b1;
        errors    = 0;
        checks    = 0;
        test_err0 = 0;
        scl_rises = 0;
        void'($urandom(32'h0aa9_2f6f));
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
            model[i] = 8'hff;
        repeat (3)
            @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        check_eq("scl", scl, 16'd1);
        check_eq("sda_oe", sda_oe, 16'd0);
        check_eq("busy", busy, 16'd0);
        check_eq("rd_valid", rd_valid, 16'd0);
        check_eq("drop_count", drop_count, 16'd0);

        for (int i = 0; i < 8; i++)
        begin
            a = 11'($urandom_range(0, 11'h6ff)); // blocks 0..6
            d = 8'($urandom);
            send(1'b1, 1'b0, a, d);
            send(1'b0, 1'b1, a, 8'h00);
        end
        drain();
        test_done("write then read back");

        for (int i = 0; i < 200; i++)
        begin
            wait_idle();
            a = 11'($urandom);
            d = 8'($urandom);
            if ($urandom_range(0, 1) == 1)
                send(1'b1, 1'b0, a, d);
            else
                send(1'b0, 1'b1, a, 8'h00);
        end
        drain();
        test_done("random mixed traffic");

        for (int i = 0; i < 4; i++)
        begin
            a = {NACK_BLK, 8'($urandom)};
            rise0 = scl_rises;
            send(1'b1, 1'b0, a, 8'($urandom));
            send(1'b0, 1'b1, a, 8'h00);
            drain();
            // device select with its ack slot plus the stop, per request
            check_eq("scl rises", 16'(scl_rises - rise0), 16'd20);
        end
        test_done("nack block");

        drop0 = drop_count;
        a = 11'($urandom_range(0, 11'h6fc));
        send(1'b1, 1'b0, a + 11'd3, 8'h5a);
        do
            @(posedge CLK);
        while (!busy);
        for (int i = 0; i < 6; i++)
        begin
            burst[i] = 8'($urandom);
            wr    <= 1'b1;
            addr  <= a + 11'(i / 2);
            wdata <= burst[i];
            @(posedge CLK);
        end
        wr <= 1'b0;
        for (int i = 0; i < `EEPROM_CMD_DEPTH; i++)
            model[a + 11'(i / 2)] = burst[i];
        drain();
        check_eq("drop_count", drop_count, 16'(drop0 + 6 - `EEPROM_CMD_DEPTH));
        for (int i = 0; i < 4; i++)
            send(1'b0, 1'b1, a + 11'(i), 8'h00);
        drain();
        test_done("command overflow");

        drop0 = drop_count;
        auto_pop <= 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            a_list[i] = 11'($urandom_range(0, 11'h6ff));
            send(1'b0, 1'b1, a_list[i], 8'h00);
        end
        d = ~exp_q[0].data; // always a new value
        send(1'b1, 1'b0, a_list[0], d);
        repeat (400)
            @(posedge CLK);
        check_eq("busy", busy, 16'd0);
        check_eq("rd_valid", rd_valid, 16'd1);
        check_eq("cmd_empty", eeprom_subsystem_i.cmd_empty, 16'd0);
        check_eq("rd_full", eeprom_subsystem_i.rd_full, 16'd1);
        check_eq("slave mem", slave_i.mem[a_list[0]], 16'(exp_q[0].data));
        auto_pop <= 1'b1;
        drain();
        send(1'b0, 1'b1, a_list[0], 8'h00);
        drain();
        check_eq("drop_count", drop_count, 16'(drop0));
        test_done("read back-pressure");

        drop0 = drop_count;
        a = 11'($urandom_range(0, 11'h6ff));
        send(1'b1, 1'b1, a, 8'($urandom));
        drain();
        check_eq("drop_count", drop_count, 16'(drop0 + 1));
        send(1'b0, 1'b1, a, 8'h00);
        drain();
        test_done("simultaneous strobes");

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/eeprom_pkg.sv
hw/eeprom_fifo.sv
hw/eeprom_req_capture.sv
hw/eeprom_serial_ctrl.sv
hw/eeprom_subsystem.sv
tb/eeprom_slave_model.sv
tb/tb_eeprom_subsystem.sv
